//--- testbench/ssf_trace.txt
# P name starts a phase. S value sends one sample. R count first sends a ramp.
# E lane value expects one result. T count total expects a result count and sum. Values in hex.
P single_lane_blocks
S 00000010
S 00000020
S 00000030
S 00000040
S fffffff0
S 00001000
S fffff800
S 00000005
E 0 000000a0
E 0 000007f5
P saturation
S 70000000
S 70000000
S 70000000
S 70000000
S 90000000
S 90000000
S 90000000
S 90000000
E 0 7fffffff
E 0 80000000
P backpressure
S 00000011
S 00000011
S 00000011
S 00000011
S 00000011
S 00000011
S 00000011
S 00000011
S 00000011
S 00000011
S 00000011
S 00000011
E 0 00000044
E 0 00000044
E 1 00000044
P all_lanes_conservation
R 64 ffffffe0
T 16 ffffffe0

//--- flist.f
source/ssf_pkg.sv
source/lane_starter.sv
source/sample_dispatcher.sv
source/ssf_lane.sv
source/result_collector.sv
source/ssf_array.sv
testbench/ssf_array_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the ssf_array testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	-f flist.f \
	--top-module ssf_array_tb \
	-Mdir obj_dir \
	-o ssf_array_sim

./obj_dir/ssf_array_sim | tee sim.log

if grep -q 'All tests passed!' sim.log; then
	echo "simulation PASSED"
else
	echo "simulation FAILED"
	exit 1
fi

//--- testbench/ssf_array_tb.sv
`timescale 1ns/1ps

module ssf_array_tb import ssf_pkg::*; ();

	localparam TRACE_FILE = "testbench/ssf_trace.txt";

	logic    clk = 1'b0;
	logic    rst;
	sample_t sample_in;
	logic    sample_valid;
	logic    sample_req;
	sample_t result_out;
	lane_t   result_lane;
	logic    result_valid;

	// trace records in file order.
	string   rec_kind [$];
	string   rec_name [$];
	int      rec_a [$];
	sample_t rec_b [$];

	// every result seen on the output, in arrival order.
	int      got_lane [$];
	sample_t got_value [$];
	int      got_count = 0;

	int      exp_lane [$];
	sample_t exp_value [$];
	logic    total_given = 1'b0;
	int      total_count;
	sample_t total_value;

	string   cur_phase = "reset_state";
	int      phase_base = 0;
	int      sent_count = 0;
	int      trace_samples = 0;
	int      cycle_count = 0;
	int      timeout_limit = 0;
	int      value_errors = 0;
	int      other_errors = 0;

	ssf_array dut (
		.clk          (clk),
		.rst          (rst),
		.sample_in    (sample_in),
		.sample_valid (sample_valid),
		.sample_req   (sample_req),
		.result_out   (result_out),
		.result_lane  (result_lane),
		.result_valid (result_valid)
	);

	always #20 clk = ~clk;

	// ============================================================
	// cycle count, timeout and result monitor.
	// ============================================================

	always @(posedge clk) begin
		if (!rst) begin
			cycle_count++;
			if (cycle_count >= timeout_limit) begin
				$display("timeout: the run did not finish within %0d cycles", timeout_limit);
				$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
				$display("Test failures found");
				$finish;
			end
		end
	end

	// outputs are registered, so the falling edge sees them settled.
	always @(negedge clk) begin
		if (rst) begin
			if (result_valid !== 1'b0) begin
				$display("Error reset_state: result_valid expected 0 actual %b", result_valid);
				value_errors++;
			end
		end else if (result_valid) begin
			got_lane.push_back(int'(result_lane));
			got_value.push_back(result_out);
			got_count++;
			if ($isunknown(result_lane) || int'(result_lane) >= NUM_LANES) begin
				$display("Error %s: result_lane expected below %0d actual %0d",
					cur_phase, NUM_LANES, result_lane);
				value_errors++;
			end
		end
	end

	// ============================================================
	// trace reading and stimulus.
	// ============================================================

	task automatic load_trace();
		int      fd;
		int      a;
		sample_t b;
		string   line;
		string   tag;
		string   name;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("could not open the trace file %s", TRACE_FILE);
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				tag  = "";
				name = "";
				a    = 1;
				b    = '0;
				void'($fgets(line, fd));
				void'($sscanf(line, "%s", tag));
				if (tag == "P") begin
					void'($sscanf(line, "%s %s", tag, name));
				end else if (tag == "S") begin
					void'($sscanf(line, "%s %h", tag, b));
				end else if (tag == "E" || tag == "R" || tag == "T") begin
					void'($sscanf(line, "%s %d %h", tag, a, b));
				end
				if (tag == "P" || tag == "S" || tag == "E" || tag == "R" || tag == "T") begin
					rec_kind.push_back(tag);
					rec_name.push_back(name);
					rec_a.push_back(a);
					rec_b.push_back(b);
				end
				if (tag == "S" || tag == "R") begin
					trace_samples += a;
				end
			end
			$fclose(fd);
		end
	endtask

	// holds the sample until a rising edge sees it accepted.
	task automatic send_sample(input sample_t value);
		logic taken;
		int   running;
		sample_in    = value;
		sample_valid = 1'b1;
		taken        = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = sample_req;
			@(posedge clk);
			#2;
		end
		sent_count++;
		// each running lane can hold at most one block that is not yet returned.
		running = 1 + (cycle_count - 1) / START_GAP;
		if (running > NUM_LANES) begin
			running = NUM_LANES;
		end
		if (sent_count - BLOCK_LEN * got_count > BLOCK_LEN * running) begin
			$display("%s: sample %0d was accepted while every running lane held a full block",
				cur_phase, sent_count);
			other_errors++;
		end
	endtask

	task automatic wait_results(input int target);
		while (got_count < target) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic start_phase(input string name);
		int ready;
		cur_phase = name;
		ready     = 0;
		// lanes 0 and 1 running, or all of them.
		if (name == "backpressure") begin
			ready = START_GAP + 2;
		end else if (name == "all_lanes_conservation") begin
			ready = (NUM_LANES - 1) * START_GAP + 2;
		end
		while (cycle_count < ready) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic finish_phase();
		int     target;
		int     idx;
		longint sum;
		sample_valid = 1'b0;
		target = total_given ? total_count : exp_value.size();
		wait_results(phase_base + target);
		// a short drain window to catch extra results.
		repeat (2 * NUM_LANES) @(posedge clk);
		#2;
		if (got_count - phase_base != target) begin
			$display("Error %s: result count expected %0d actual %0d",
				cur_phase, target, got_count - phase_base);
			value_errors++;
		end
		for (int i = 0; i < exp_value.size(); i++) begin
			idx = phase_base + i;
			if (idx < got_count && got_lane[idx] != exp_lane[i]) begin
				$display("Error %s: result %0d lane expected %0d actual %0d",
					cur_phase, i, exp_lane[i], got_lane[idx]);
				value_errors++;
			end
			if (idx < got_count && got_value[idx] !== exp_value[i]) begin
				$display("Error %s: result %0d value expected %h actual %h",
					cur_phase, i, exp_value[i], got_value[idx]);
				value_errors++;
			end
		end
		if (total_given) begin
			sum = 0;
			for (int i = phase_base; i < got_count; i++) begin
				sum += longint'(got_value[i]);
			end
			if (sum != longint'(total_value)) begin
				$display("Error %s: result total expected %0d actual %0d",
					cur_phase, longint'(total_value), sum);
				value_errors++;
			end
		end
		exp_lane.delete();
		exp_value.delete();
		total_given = 1'b0;
		phase_base  = got_count;
	endtask

	task automatic run_trace();
		logic open;
		open = 1'b0;
		for (int i = 0; i < rec_kind.size(); i++) begin
			if (rec_kind[i] == "P") begin
				if (open) begin
					finish_phase();
				end
				start_phase(rec_name[i]);
				open = 1'b1;
			end else if (rec_kind[i] == "S") begin
				send_sample(rec_b[i]);
			end else if (rec_kind[i] == "R") begin
				for (int k = 0; k < rec_a[i]; k++) begin
					send_sample(sample_t'(rec_b[i] + k));
				end
			end else if (rec_kind[i] == "E") begin
				exp_lane.push_back(rec_a[i]);
				exp_value.push_back(rec_b[i]);
			end else begin
				total_given = 1'b1;
				total_count = rec_a[i];
				total_value = rec_b[i];
			end
		end
		if (open) begin
			finish_phase();
		end
	endtask

	task automatic check_reset_exit();
		@(negedge clk);
		if (sample_req !== 1'b1) begin
			$display("Error reset_state: sample_req expected 1 actual %b", sample_req);
			value_errors++;
		end
		if (result_valid !== 1'b0) begin
			$display("Error reset_state: result_valid expected 0 actual %b", result_valid);
			value_errors++;
		end
		@(posedge clk);
		#2;
	endtask

	// ============================================================
	// main sequence.
	// ============================================================

	initial begin
		rst          = 1'b1;
		sample_in    = '0;
		sample_valid = 1'b0;
		load_trace();
		timeout_limit = 40 * trace_samples + 8 * START_GAP + 200;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		check_reset_exit();
		run_trace();
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- source/ssf_array.sv
`timescale 1ns/1ps

module ssf_array import ssf_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  sample_t sample_in,
	input  logic    sample_valid,
	output logic    sample_req,
	output sample_t result_out,
	output lane_t   result_lane,
	output logic    result_valid
);

	lane_mask_t lane_run;
	lane_mask_t lane_req;
	lane_mask_t lane_grant;
	lane_mask_t lane_load;
	sample_t    lane_data;
	lane_mask_t lane_pending;
	lane_mask_t lane_ack;
	sample_t    lane_result [NUM_LANES];

	// ============================================================
	// shared control.
	// ============================================================

	lane_starter u_starter (
		.clk      (clk),
		.rst      (rst),
		.lane_run (lane_run)
	);

	sample_dispatcher u_dispatcher (
		.clk          (clk),
		.rst          (rst),
		.sample_in    (sample_in),
		.sample_valid (sample_valid),
		.lane_req     (lane_req),
		.sample_req   (sample_req),
		.lane_grant   (lane_grant),
		.lane_data    (lane_data),
		.lane_load    (lane_load)
	);

	// ============================================================
	// lanes.
	// ============================================================

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		ssf_lane u_lane (
			.clk     (clk),
			.rst     (rst),
			.run     (lane_run[i]),
			.grant   (lane_grant[i]),
			.load    (lane_load[i]),
			.data    (lane_data),
			.ack     (lane_ack[i]),
			.req     (lane_req[i]),
			.pending (lane_pending[i]),
			.result  (lane_result[i])
		);
	end

	result_collector u_collector (
		.clk          (clk),
		.rst          (rst),
		.lane_pending (lane_pending),
		.lane_result  (lane_result),
		.lane_ack     (lane_ack),
		.result_out   (result_out),
		.result_lane  (result_lane),
		.result_valid (result_valid)
	);

endmodule

//--- source/result_collector.sv
`timescale 1ns/1ps

module result_collector import ssf_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  lane_mask_t lane_pending,
	input  sample_t    lane_result [NUM_LANES],
	output lane_mask_t lane_ack,
	output sample_t    result_out,
	output lane_t      result_lane,
	output logic       result_valid
);

	logic  pick_found;
	lane_t pick_lane;

	// ============================================================
	// priority search over pending lanes.
	// ============================================================

	// lowest index wins.
	always_comb begin
		pick_found = 1'b0;
		pick_lane  = '0;
		for (int i = NUM_LANES - 1; i >= 0; i--) begin
			if (lane_pending[i]) begin
				pick_found = 1'b1;
				pick_lane  = lane_t'(i);
			end
		end
	end

	// the chosen lane drops pending on the edge that registers its result.
	always_comb begin
		lane_ack = '0;
		if (pick_found) begin
			lane_ack[pick_lane] = 1'b1;
		end
	end

	// ============================================================
	// output register.
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= pick_found;
		end
	end

	always_ff @(posedge clk) begin
		if (pick_found) begin
			result_out  <= lane_result[pick_lane];
			result_lane <= pick_lane;
		end
	end

endmodule

//--- source/ssf_lane.sv
`timescale 1ns/1ps

module ssf_lane import ssf_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    run,
	input  logic    grant,
	input  logic    load,
	input  sample_t data,
	input  logic    ack,
	output logic    req,
	output logic    pending,
	output sample_t result
);

	lane_state_t state;
	count_t      taken;
	acc_t        sum;
	acc_t        next_sum;
	logic        last_add;

	// clamp a block sum into the sample range.
	function automatic sample_t saturate(input acc_t value);
		sample_t clamped;
		if (value > acc_t'(SAMPLE_MAX)) begin
			clamped = SAMPLE_MAX;
		end else if (value < acc_t'(SAMPLE_MIN)) begin
			clamped = SAMPLE_MIN;
		end else begin
			clamped = sample_t'(value);
		end
		return clamped;
	endfunction

	// ============================================================
	// request and completion.
	// ============================================================

	// loads arrive in grant order, so a load seen with a full count is the last one.
	assign next_sum = sum + acc_t'(data);
	assign last_add = load && (taken == count_t'(BLOCK_LEN));

	assign req     = run && (state != HOLDING) && (taken != count_t'(BLOCK_LEN));
	assign pending = (state == HOLDING);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			taken <= '0;
			sum   <= '0;
		end else begin
			if (grant) begin
				taken <= taken + 1'b1;
			end
			case (state)
				IDLE: begin
					if (run) begin
						state <= FILLING;
					end
				end
				FILLING: begin
					if (load) begin
						sum <= next_sum;
					end
					if (last_add) begin
						state <= HOLDING;
					end
				end
				HOLDING: begin
					// result has been taken by the collector.
					if (ack) begin
						state <= FILLING;
						taken <= '0;
						sum   <= '0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// held result word.
	always_ff @(posedge clk) begin
		if (last_add) begin
			result <= saturate(next_sum);
		end
	end

endmodule

//--- source/sample_dispatcher.sv
`timescale 1ns/1ps

module sample_dispatcher import ssf_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  sample_t    sample_in,
	input  logic       sample_valid,
	input  lane_mask_t lane_req,
	output logic       sample_req,
	output lane_mask_t lane_grant,
	output sample_t    lane_data,
	output lane_mask_t lane_load
);

	logic accept;

	// any asking lane opens the input.
	assign sample_req = |lane_req;
	assign accept     = sample_valid & sample_req;

	// ============================================================
	// grant to the lowest asking lane.
	// ============================================================

	// scanning from the top down leaves the lowest set bit as the winner.
	always_comb begin
		lane_grant = '0;
		if (accept) begin
			for (int i = NUM_LANES - 1; i >= 0; i--) begin
				if (lane_req[i]) begin
					lane_grant    = '0;
					lane_grant[i] = 1'b1;
				end
			end
		end
	end

	// ============================================================
	// delivery one cycle after the grant.
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			lane_load <= '0;
		end else begin
			lane_load <= lane_grant;
		end
	end

	// sample word is shared by all lanes, lane_load picks the taker.
	always_ff @(posedge clk) begin
		if (accept) begin
			lane_data <= sample_in;
		end
	end

endmodule

//--- source/lane_starter.sv
`timescale 1ns/1ps

module lane_starter import ssf_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	output lane_mask_t lane_run
);

	gap_cnt_t gap_cnt;
	logic     all_running;

	// the top lane is the last one to be released.
	assign all_running = lane_run[NUM_LANES-1];

	// ============================================================
	// staggered release.
	// ============================================================

	// lane 0 runs straight out of reset, each further lane follows
	// START_GAP cycles after the one below it.
	always_ff @(posedge clk) begin
		if (rst) begin
			lane_run <= lane_mask_t'(1);
			gap_cnt  <= '0;
		end else if (!all_running) begin
			if (gap_cnt == gap_cnt_t'(START_GAP - 1)) begin
				gap_cnt  <= '0;
				lane_run <= {lane_run[NUM_LANES-2:0], 1'b1};
			end else begin
				gap_cnt <= gap_cnt + 1'b1;
			end
		end
	end

endmodule

//--- source/ssf_pkg.sv
package ssf_pkg;

	// ============================================================
	// array geometry.
	// ============================================================

	localparam int NUM_LANES = 8;
	localparam int BLOCK_LEN = 4;
	localparam int START_GAP = 64;
	localparam int SAMPLE_W  = 32;
	localparam int LANE_W    = $clog2(NUM_LANES);

	// accumulator needs headroom for BLOCK_LEN full-scale samples plus sign.
	localparam int ACC_W = SAMPLE_W + $clog2(BLOCK_LEN) + 1;

	// counter widths for the release spacing and the taken-sample count.
	localparam int GAP_W = $clog2(START_GAP);
	localparam int CNT_W = $clog2(BLOCK_LEN + 1);

	// ============================================================
	// vector types.
	// ============================================================

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [ACC_W-1:0]    acc_t;
	typedef logic [LANE_W-1:0]          lane_t;
	typedef logic [NUM_LANES-1:0]       lane_mask_t;
	typedef logic [GAP_W-1:0]           gap_cnt_t;
	typedef logic [CNT_W-1:0]           count_t;

	// saturation limits of a sample.
	localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

	typedef enum logic [1:0] {
		FILLING,
		HOLDING,
		IDLE
	} lane_state_t;

endpackage
